/* intra4_pkg.sv */
package intra4_pkg;

    // --------------------
    // Sample types
    // --------------------
    typedef logic        [7:0] pixel_t;
    typedef logic signed [8:0] resid_t;

    // Four samples, element 0 at the left or top
    typedef pixel_t [3:0] pix_row_t;

    // Sample r*4+c sits at row r, column c
    typedef pixel_t [15:0] pix_blk_t;
    typedef resid_t [15:0] resid_blk_t;

    // Reconstructed pixels around the macroblock
    typedef struct packed {
        pixel_t [15:0] top;   // leftmost first
        pixel_t [15:0] left;  // topmost first
    } mb_edge_t;

    // --------------------
    // Prediction modes
    // --------------------
    typedef logic [1:0] mode_t;

    localparam mode_t MODE_VERT = 2'd0;
    localparam mode_t MODE_HORZ = 2'd1;
    localparam mode_t MODE_DC   = 2'd2;
    localparam mode_t MODE_RSVD = 2'd3;

    typedef mode_t [15:0] mb_modes_t;

    // Block row in [3:2], block column in [1:0]
    typedef logic [3:0] blk_idx_t;

    localparam blk_idx_t LAST_BLK = 4'd15;

    // Selected neighbors of the current block
    typedef struct packed {
        pix_row_t top;
        pix_row_t left;
    } nbr_t;

endpackage

/* intra4_seq.sv */
`timescale 1ns/1ns

module intra4_seq (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mb_start_i,
    input  intra4_pkg::mb_modes_t mb_modes_i,
    input  logic                  blk_valid_i,
    output logic                  busy_o,
    output intra4_pkg::blk_idx_t  blk_idx_o,
    output intra4_pkg::mode_t     mode_o,
    output logic                  blk_fire_o,
    output logic                  last_o
);

    import intra4_pkg::*;

    mb_modes_t modes_q;
    blk_idx_t  idx_q;
    logic      busy_q;

    // Strobes outside a macroblock are dropped
    assign blk_fire_o = blk_valid_i & busy_q;
    assign last_o     = blk_fire_o && (idx_q == LAST_BLK);

    assign busy_o    = busy_q;
    assign blk_idx_o = idx_q;
    assign mode_o    = modes_q[idx_q];

    // Mode table, loaded once per macroblock
    always_ff @(posedge clk) begin
        if (mb_start_i) begin
            modes_q <= mb_modes_i;
        end
    end

    // Block counter and busy flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
        end else if (mb_start_i) begin
            busy_q <= 1'b1;
            idx_q  <= '0;
        end else if (blk_fire_o) begin
            // Wraps back to 0 after block 15
            idx_q <= idx_q + 4'd1;
            if (last_o) begin
                busy_q <= 1'b0;
            end
        end
    end

    // --------------------
    // Protocol checks
    // --------------------
    // Next macroblock only after block 15 went through
    assert property (@(posedge clk) disable iff (!rst_n) mb_start_i |-> !busy_q)
        else $error("intra4_seq: mb_start_i while a macroblock is busy");

    // Table entry used by a block must be a defined mode
    assert property (@(posedge clk) disable iff (!rst_n) blk_fire_o |-> mode_o != MODE_RSVD)
        else $error("intra4_seq: reserved mode for block %0d", idx_q);

endmodule

/* intra4_nbr_buf.sv */
`timescale 1ns/1ns

module intra4_nbr_buf (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 mb_start_i,
    input  intra4_pkg::mb_edge_t mb_edge_i,
    input  intra4_pkg::blk_idx_t blk_idx_i,
    input  logic                 recon_valid_i,
    input  intra4_pkg::pix_blk_t recon_i,
    input  intra4_pkg::blk_idx_t recon_idx_i,
    output intra4_pkg::nbr_t     nbr_o
);

    import intra4_pkg::*;

    // Edge of the current macroblock
    mb_edge_t edge_q;

    // Bottom rows of the latest block in each column
    pix_row_t top_mem [4];

    // Right column of the last reconstructed block
    pix_row_t left_q;

    logic [1:0] blk_row;
    logic [1:0] blk_col;
    logic [1:0] rec_col;
    pix_row_t   rec_bottom;
    pix_row_t   rec_right;
    pix_row_t   edge_top;
    pix_row_t   edge_left;
    pix_row_t   prev_right;

    assign blk_row = blk_idx_i[3:2];
    assign blk_col = blk_idx_i[1:0];
    assign rec_col = recon_idx_i[1:0];

    // --------------------
    // Slices of incoming data
    // --------------------
    // Bottom row and right column of the returning block
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rec_bottom[i] = recon_i[12 + i];
            rec_right[i]  = recon_i[4 * i + 3];
        end
    end

    // Edge pixels facing the current block
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            edge_top[i]  = edge_q.top[{blk_col, 2'(i)}];
            edge_left[i] = edge_q.left[{blk_row, 2'(i)}];
        end
    end

    // --------------------
    // Storage
    // --------------------
    always_ff @(posedge clk) begin
        if (mb_start_i) begin
            edge_q <= mb_edge_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < 4; c++) begin
                top_mem[c] <= '0;
            end
            left_q <= '0;
        end else if (recon_valid_i) begin
            top_mem[rec_col] <= rec_bottom;
            left_q           <= rec_right;
        end
    end

    // --------------------
    // Neighbor selection
    // --------------------
    // Back-to-back blocks see the left neighbor before it is stored
    assign prev_right = recon_valid_i ? rec_right : left_q;

    // Block above is at least four blocks back, always stored by now
    assign nbr_o.top  = (blk_row == 2'd0) ? edge_top : top_mem[blk_col];

    // Block to the left is the one just reconstructed
    assign nbr_o.left = (blk_col == 2'd0) ? edge_left : prev_right;

    // Returning block must be the one right before the current index
    assert property (@(posedge clk) disable iff (!rst_n)
                     recon_valid_i |-> recon_idx_i == blk_idx_t'(blk_idx_i - 4'd1))
        else $error("intra4_nbr_buf: recon index %0d out of order at index %0d",
                    recon_idx_i, blk_idx_i);

endmodule

/* intra4_pred.sv */
`timescale 1ns/1ns

module intra4_pred (
    input  intra4_pkg::nbr_t     nbr_i,
    input  intra4_pkg::mode_t    mode_i,
    output intra4_pkg::pix_blk_t pred_o
);

    import intra4_pkg::*;

    // Up to 8 * 255 + 4, fits in 11 bits
    logic [10:0] dc_sum;
    pixel_t      dc_val;

    pix_blk_t vert_blk;
    pix_blk_t horz_blk;
    pix_blk_t dc_blk;

    // --------------------
    // DC value
    // --------------------
    // Rounded mean of four top and four left pixels
    always_comb begin
        dc_sum = 11'd4;
        for (int i = 0; i < 4; i++) begin
            dc_sum = dc_sum + 11'(nbr_i.top[i]) + 11'(nbr_i.left[i]);
        end
    end

    assign dc_val = dc_sum[10:3];

    // --------------------
    // Candidate blocks
    // --------------------
    always_comb begin
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                // Column c repeats top pixel c
                vert_blk[4 * r + c] = nbr_i.top[c];
                // Row r repeats left pixel r
                horz_blk[4 * r + c] = nbr_i.left[r];
                dc_blk[4 * r + c]   = dc_val;
            end
        end
    end

    // --------------------
    // Mode select
    // --------------------
    always_comb begin
        case (mode_i)
            MODE_VERT: pred_o = vert_blk;
            MODE_HORZ: pred_o = horz_blk;
            MODE_DC:   pred_o = dc_blk;
            // Reserved code falls back to DC
            default:   pred_o = dc_blk;
        endcase
    end

endmodule

/* intra4_recon.sv */
`timescale 1ns/1ns

module intra4_recon (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   fire_i,
    input  intra4_pkg::blk_idx_t   idx_i,
    input  logic                   last_i,
    input  intra4_pkg::pix_blk_t   pred_i,
    input  intra4_pkg::resid_blk_t resid_i,
    output logic                   recon_valid_o,
    output intra4_pkg::pix_blk_t   recon_o,
    output intra4_pkg::blk_idx_t   recon_idx_o,
    output logic                   mb_done_o
);

    import intra4_pkg::*;

    pix_blk_t sum_blk;

    // Prediction plus residual, clipped to 0..255
    always_comb begin
        logic signed [10:0] s;
        for (int i = 0; i < 16; i++) begin
            s = $signed({3'b000, pred_i[i]})
              + $signed({{2{resid_i[i][8]}}, resid_i[i]});
            if (s[10]) begin
                sum_blk[i] = 8'd0;
            end else if (|s[9:8]) begin
                sum_blk[i] = 8'd255;
            end else begin
                sum_blk[i] = s[7:0];
            end
        end
    end

    // --------------------
    // Output stage
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            recon_valid_o <= 1'b0;
            mb_done_o     <= 1'b0;
        end else begin
            recon_valid_o <= fire_i;
            mb_done_o     <= fire_i & last_i;
        end
    end

    always_ff @(posedge clk) begin
        if (fire_i) begin
            recon_o     <= sum_blk;
            recon_idx_o <= idx_i;
        end
    end

    // Done marks the strobe of the last block only
    assert property (@(posedge clk) disable iff (!rst_n)
                     mb_done_o |-> recon_valid_o && recon_idx_o == LAST_BLK)
        else $error("intra4_recon: mb_done_o without block 15 strobe");

endmodule

/* intra4_top.sv */
`timescale 1ns/1ns

module intra4_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   mb_start_i,
    input  intra4_pkg::mb_edge_t   mb_edge_i,
    input  intra4_pkg::mb_modes_t  mb_modes_i,
    input  logic                   blk_valid_i,
    input  intra4_pkg::resid_blk_t blk_resid_i,
    output logic                   recon_valid_o,
    output intra4_pkg::pix_blk_t   recon_o,
    output intra4_pkg::blk_idx_t   recon_idx_o,
    output logic                   mb_done_o
);

    import intra4_pkg::*;

    blk_idx_t blk_idx;
    mode_t    cur_mode;
    logic     blk_fire;
    logic     blk_last;
    nbr_t     nbr;
    pix_blk_t pred;

    intra4_seq u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .mb_start_i  (mb_start_i),
        .mb_modes_i  (mb_modes_i),
        .blk_valid_i (blk_valid_i),
        .busy_o      (),
        .blk_idx_o   (blk_idx),
        .mode_o      (cur_mode),
        .blk_fire_o  (blk_fire),
        .last_o      (blk_last)
    );

    intra4_nbr_buf u_nbr (
        .clk           (clk),
        .rst_n         (rst_n),
        .mb_start_i    (mb_start_i),
        .mb_edge_i     (mb_edge_i),
        .blk_idx_i     (blk_idx),
        .recon_valid_i (recon_valid_o),
        .recon_i       (recon_o),
        .recon_idx_i   (recon_idx_o),
        .nbr_o         (nbr)
    );

    intra4_pred u_pred (
        .nbr_i  (nbr),
        .mode_i (cur_mode),
        .pred_o (pred)
    );

    intra4_recon u_recon (
        .clk           (clk),
        .rst_n         (rst_n),
        .fire_i        (blk_fire),
        .idx_i         (blk_idx),
        .last_i        (blk_last),
        .pred_i        (pred),
        .resid_i       (blk_resid_i),
        .recon_valid_o (recon_valid_o),
        .recon_o       (recon_o),
        .recon_idx_o   (recon_idx_o),
        .mb_done_o     (mb_done_o)
    );

endmodule

/* tb_intra4.sv */
`timescale 1ns/1ns

module tb_intra4;

    import intra4_pkg::*;

    localparam int TIMEOUT_CYCLES = 16;
    localparam int MB_WORDS       = 34;

    logic       clk;
    logic       rst_n;
    logic       mb_start;
    mb_edge_t   mb_edge;
    mb_modes_t  mb_modes;
    logic       blk_valid;
    resid_blk_t blk_resid;
    logic       recon_valid;
    pix_blk_t   recon;
    blk_idx_t   recon_idx;
    logic       mb_done;

    // Per macroblock: edge, modes, then residual and expected block pairs
    logic [255:0] golden_mem [0:2*MB_WORDS-1];

    integer seed;
    string  test_name;
    int     test_errors;
    int     tests_passed;
    int     tests_failed;

    intra4_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .mb_start_i    (mb_start),
        .mb_edge_i     (mb_edge),
        .mb_modes_i    (mb_modes),
        .blk_valid_i   (blk_valid),
        .blk_resid_i   (blk_resid),
        .recon_valid_o (recon_valid),
        .recon_o       (recon),
        .recon_idx_o   (recon_idx),
        .mb_done_o     (mb_done)
    );

    always #2 clk = ~clk;

    // --------------------
    // Helpers
    // --------------------
    task automatic check_value(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: %s expected %h actual %h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic close_test();
        if (test_errors == 0) begin
            $display("PASS %s", test_name);
            tests_passed++;
        end else begin
            $display("FAIL %s with %0d errors", test_name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    // Strobe of the block issued at the current falling edge
    task automatic wait_recon(output bit seen, output int cycles);
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            blk_valid = 1'b0;
            cycles++;
            seen = recon_valid;
        end
    endtask

    task automatic run_mb(input int mb, input bit gapped);
        int base;
        int gap;
        int cycles;
        bit seen;
        base = mb * MB_WORDS;
        @(negedge clk);
        mb_start = 1'b1;
        mb_edge  = golden_mem[base];
        mb_modes = golden_mem[base + 1][31:0];
        @(negedge clk);
        mb_start = 1'b0;
        for (int k = 0; k < 16; k++) begin
            gap = gapped ? ($random(seed) & 3) : 0;
            for (int g = 0; g < gap; g++) begin
                @(negedge clk);
                check_value("strobe between blocks", '0, 128'({recon_valid, mb_done}));
            end
            blk_valid = 1'b1;
            blk_resid = golden_mem[base + 2 + 2 * k][143:0];
            wait_recon(seen, cycles);
            if (!seen) begin
                $display("TIMEOUT %s: no recon_valid_o for block %0d", test_name, k);
                test_errors++;
            end else begin
                check_value($sformatf("block %0d latency", k), 128'(1), 128'(cycles));
                check_value($sformatf("block %0d recon_idx_o", k), 128'(k), 128'(recon_idx));
                check_value($sformatf("block %0d mb_done_o", k), 128'(k == 15), 128'(mb_done));
                check_value($sformatf("block %0d recon_o", k),
                            golden_mem[base + 3 + 2 * k][127:0], recon);
            end
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        mb_start     = 1'b0;
        mb_edge      = '0;
        mb_modes     = '0;
        blk_valid    = 1'b0;
        blk_resid    = '0;
        seed         = 32'h327e;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        $readmemh("intra4_golden.txt", golden_mem);
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Strobes with no macroblock open
        test_name = "reset_idle";
        for (int i = 0; i < 8; i++) begin
            blk_valid = (i < 3);
            @(negedge clk);
            check_value("idle outputs", '0, 128'({recon_valid, mb_done}));
        end
        blk_valid = 1'b0;
        close_test();

        test_name = "mb_vertical_b2b";
        run_mb(0, 1'b0);
        close_test();

        test_name = "mb_mixed_gaps";
        run_mb(1, 1'b1);
        close_test();

        // Same data without gaps, left neighbor taken straight from the strobe
        test_name = "mb_mixed_b2b";
        run_mb(1, 1'b0);
        close_test();

        $display("%0d tests passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* intra4_golden.txt */
// edge: top[15..0] then left[15..0], one byte each; modes[15..0], two bits each
// per block: residual[15..0], nine bits each; expected recon[15..0], one byte each
FFEEDDCCBBAA9988776655443322110040404040404040404040404040404040 00000000
000000000000000000000000000000000000 33221100332211003322110033221100
000000000000000000000000000000000000 77665544776655447766554477665544
000000000000000000000000000000000000 BBAA9988BBAA9988BBAA9988BBAA9988
000000000000000000000000000000000000 FFEEDDCCFFEEDDCCFFEEDDCCFFEEDDCC
000000000000000000000000000000000000 33221100332211003322110033221100
000000000000000000000000000000000000 77665544776655447766554477665544
000000000000000000000000000000000000 BBAA9988BBAA9988BBAA9988BBAA9988
000000000000000000000000000000000000 FFEEDDCCFFEEDDCCFFEEDDCCFFEEDDCC
000000000000000000000000000000000000 33221100332211003322110033221100
000000000000000000000000000000000000 77665544776655447766554477665544
000000000000000000000000000000000000 BBAA9988BBAA9988BBAA9988BBAA9988
000000000000000000000000000000000000 FFEEDDCCFFEEDDCCFFEEDDCCFFEEDDCC
000000000000000000000000000000000000 33221100332211003322110033221100
000000000000000000000000000000000000 77665544776655447766554477665544
000000000000000000000000000000000000 BBAA9988BBAA9988BBAA9988BBAA9988
000000000000000000000000000000000000 FFEEDDCCFFEEDDCCFFEEDDCCFFEEDDCC
B0A0908002040608FCF8F4F04030201044332211706050400E0A0602FEFAF6F2 25A58961
040201008040201008040201008040201008 FFFFFFFFFFFFFFFFFEFEFEFEFAFAFAFA
FC7E3F1F8FC7E3F1F8FC7E3F1F8FC7E3F1F8 F4F0ECE8F4F0ECE8F4F0ECE8F4F0ECE8
000000000000000000000000000000000000 7D7D7D7D7D7D7D7D7D7D7D7D7D7D7D7D
040201008040201008040201008040201008 85858585858585858585858585858585
FC7E3F1F8FC7E3F1F8FC7E3F1F8FC7E3F1F8 06060606020202020000000000000000
000000000000000000000000000000000000 78787878787878787878787878787878
7FBFDFEFF7FBFDFEFF7FBFDFEFF7FBFDFEFF FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
FC7E3F1F8FC7E3F1F8FC7E3F1F8FC7E3F1F8 BABABABABABABABABABABABABABABABA
000000000000000000000000000000000000 70707070606060605050505040404040
040201008040201008040201008040201008 78787878686868685858585848484848
804020100804020100804020100804020100 00000000000000000000000000000000
040201008040201008040201008040201008 65656565656565656565656565656565
FC7E3F1F8FC7E3F1F8FC7E3F1F8FC7E3F1F8 3C3C3C3C2B2B2B2B1A1A1A1A09090909
040201008040201008040201008040201008 44444444333333332222222211111111
000000000000000000000000000000000000 15151515151515151515151515151515
FC7E3F1F8FC7E3F1F8FC7E3F1F8FC7E3F1F8 5D5D5D5D5D5D5D5D5D5D5D5D5D5D5D5D

/* files.f */
intra4_pkg.sv
intra4_seq.sv
intra4_nbr_buf.sv
intra4_pred.sv
intra4_recon.sv
intra4_top.sv
tb_intra4.sv

/* run.sh */
#!/bin/sh
# Build and run the intra 4x4 testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_intra4 \
    -Mdir obj_dir -o tb_intra4
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_intra4 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0
